/* Bender.yml */
package:
  name: alu_unit

sources:
  - alu_unit_pkg.sv
  - alu_ctrl_if.sv
  - alu.sv
  - alu_sequencer.sv
  - operand_regs.sv
  - status_flags.sv
  - alu_unit_top.sv
  - target: test
    files:
      - alu_unit_checker.sv
      - tb_alu_unit.sv

/* alu.sv */
`timescale 1ns/100ps
`default_nettype none

module alu (
    input  logic [alu_unit_pkg::DATA_W-1:0] DB_input,
    input  logic [alu_unit_pkg::DATA_W-1:0] SB_input,
    alu_ctrl_if.alu                         ctrl
);
    import alu_unit_pkg::*;

    logic [DATA_W-1:0] a;
    logic [DATA_W-1:0] b;
    logic [DATA_W:0]   bin_sum;        // includes carry out
    logic              dec_mode;

    logic [4:0]        lo_raw;
    logic [4:0]        hi_raw;
    logic [3:0]        lo_adj;
    logic [3:0]        hi_adj;
    logic              half_carry;
    logic              dec_carry;

    // operand select, true operand wins over inverted
    always_comb begin
        a = '0;
        b = '0;
        if (ctrl.ldb_inv_db) begin
            b = ~DB_input;
        end
        if (ctrl.ldb_db) begin
            b = DB_input;
        end
        if (ctrl.lda_sb) begin
            a = SB_input;
        end
    end

    assign bin_sum  = {1'b0, a} + {1'b0, b} + {{DATA_W{1'b0}}, ctrl.carry_in};
    assign dec_mode = ctrl.enable_dec & ctrl.e_sum;

    // signed overflow, undefined in decimal so forced low
    assign ctrl.overflow = (a[7] ^ bin_sum[7]) & (b[7] ^ bin_sum[7]) & ~dec_mode;

    // Decimal correction per nibble. For subtract, b already holds the
    // inverted operand, so a missing nibble carry means a borrow and the
    // digit is pulled back by 6.
    always_comb begin
        lo_raw     = {1'b0, a[3:0]} + {1'b0, b[3:0]} + {4'd0, ctrl.carry_in};
        lo_adj     = lo_raw[3:0];
        half_carry = lo_raw[4];
        if (!ctrl.subtracting) begin
            if (lo_raw > 5'd9) begin
                lo_adj     = lo_raw[3:0] + 4'd6;  // skip a..f
                half_carry = 1'b1;
            end
        end else if (!lo_raw[4]) begin
            lo_adj = lo_raw[3:0] - 4'd6;          // borrow from low digit
        end

        hi_raw    = {1'b0, a[7:4]} + {1'b0, b[7:4]} + {4'd0, half_carry};
        hi_adj    = hi_raw[3:0];
        dec_carry = hi_raw[4];
        if (!ctrl.subtracting) begin
            if (hi_raw > 5'd9) begin
                hi_adj    = hi_raw[3:0] + 4'd6;
                dec_carry = 1'b1;
            end
        end else if (!hi_raw[4]) begin
            hi_adj = hi_raw[3:0] - 4'd6;
        end
    end

    // function select
    always_comb begin
        ctrl.alu_out   = '0;
        ctrl.carry_out = 1'b0;
        if (ctrl.e_sum) begin
            if (dec_mode) begin
                ctrl.alu_out   = {hi_adj, lo_adj};
                ctrl.carry_out = dec_carry;
            end else begin
                ctrl.alu_out   = bin_sum[DATA_W-1:0];
                ctrl.carry_out = bin_sum[DATA_W];
            end
        end else if (ctrl.e_and) begin
            ctrl.alu_out = a & b;
        end else if (ctrl.e_eor) begin
            ctrl.alu_out = a ^ b;
        end else if (ctrl.e_or) begin
            ctrl.alu_out = a | b;
        end else if (ctrl.e_shiftr) begin
            {ctrl.alu_out, ctrl.carry_out} = {ctrl.carry_in, a}; // rotate through carry_in
        end
    end

endmodule

`default_nettype wire

/* alu_ctrl_if.sv */
`timescale 1ns/100ps
`default_nettype none

interface alu_ctrl_if;
    import alu_unit_pkg::*;

    logic ldb_db;                  // operand on b
    logic ldb_inv_db;              // inverted operand on b
    logic lda_sb;                  // accumulator on a
    logic e_sum;
    logic e_and;
    logic e_eor;
    logic e_or;
    logic e_shiftr;
    logic enable_dec;              // bcd add/subtract
    logic subtracting;
    logic carry_in;
    alu_op_e op;                   // latched opcode
    logic flag_we;                 // write-back strobe

    logic [DATA_W-1:0] alu_out;
    logic carry_out;
    logic overflow;

    modport seq (
        output ldb_db, ldb_inv_db, lda_sb,
        output e_sum, e_and, e_eor, e_or, e_shiftr,
        output enable_dec, subtracting, carry_in,
        output op, flag_we
    );

    modport alu (
        input  ldb_db, ldb_inv_db, lda_sb,
        input  e_sum, e_and, e_eor, e_or, e_shiftr,
        input  enable_dec, subtracting, carry_in,
        output alu_out, carry_out, overflow
    );

    modport flags (
        input op, flag_we, alu_out, carry_out, overflow
    );

endinterface

`default_nettype wire

/* alu_sequencer.sv */
`timescale 1ns/100ps
`default_nettype none

module alu_sequencer (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            cyc,
    input  logic                            stb,
    input  logic                            we,
    input  logic [alu_unit_pkg::ADDR_W-1:0] adr,
    input  logic [alu_unit_pkg::DATA_W-1:0] dat_w,
    output logic [alu_unit_pkg::DATA_W-1:0] dat_r,
    output logic                            ack,
    input  logic [alu_unit_pkg::DATA_W-1:0] acc,
    input  logic [alu_unit_pkg::DATA_W-1:0] operand,
    input  logic [alu_unit_pkg::DATA_W-1:0] status,
    output logic                            acc_we_host,
    output logic                            operand_we_host,
    output logic                            status_we_host,
    output logic                            acc_we_alu,
    alu_ctrl_if.seq                         ctrl
);
    import alu_unit_pkg::*;

    seq_state_e state;
    alu_op_e    op_q;
    logic       access;        // new bus cycle seen in idle
    logic       host_write;
    logic       opcode_write;

    assign access       = (state == ST_IDLE) && cyc && stb;
    assign host_write   = access && we;
    assign opcode_write = host_write && (adr == ADDR_OPCODE);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= ST_IDLE;
            op_q  <= OP_ADC;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (opcode_write) begin
                        op_q  <= alu_op_e'(dat_w[2:0]);
                        state <= ST_EXEC;
                    end else if (access) begin
                        state <= ST_ACK;         // plain register access
                    end
                end
                ST_EXEC: state <= ST_ACK;        // result written this edge
                ST_ACK:  state <= ST_IDLE;
                default: state <= ST_IDLE;
            endcase
        end
    end

    assign ack = (state == ST_ACK);

    // host strobes land on the edge that leaves idle
    assign acc_we_host     = host_write && (adr == ADDR_ACC);
    assign operand_we_host = host_write && (adr == ADDR_OPERAND);
    assign status_we_host  = host_write && (adr == ADDR_STATUS);

    // write-back strobes, cmp only touches the flags
    assign ctrl.flag_we = (state == ST_EXEC);
    assign acc_we_alu   = (state == ST_EXEC) && (op_q != OP_CMP);
    assign ctrl.op      = op_q;

    always_comb begin
        case (adr)
            ADDR_ACC:     dat_r = acc;
            ADDR_OPERAND: dat_r = operand;
            ADDR_STATUS:  dat_r = status;
            default:      dat_r = '0;        // opcode and unused slots
        endcase
    end

    // opcode to alu controls
    always_comb begin
        ctrl.ldb_db      = 1'b0;
        ctrl.ldb_inv_db  = 1'b0;
        ctrl.lda_sb      = 1'b1;        // a is always the accumulator
        ctrl.e_sum       = 1'b0;
        ctrl.e_and       = 1'b0;
        ctrl.e_eor       = 1'b0;
        ctrl.e_or        = 1'b0;
        ctrl.e_shiftr    = 1'b0;
        ctrl.enable_dec  = 1'b0;
        ctrl.subtracting = 1'b0;
        ctrl.carry_in    = 1'b0;
        case (op_q)
            OP_ADC: begin
                ctrl.ldb_db     = 1'b1;
                ctrl.e_sum      = 1'b1;
                ctrl.enable_dec = status[FLAG_D];
                ctrl.carry_in   = status[FLAG_C];
            end
            OP_SBC: begin
                ctrl.ldb_inv_db  = 1'b1;
                ctrl.e_sum       = 1'b1;
                ctrl.subtracting = 1'b1;
                ctrl.enable_dec  = status[FLAG_D];
                ctrl.carry_in    = status[FLAG_C];
            end
            OP_CMP: begin
                ctrl.ldb_inv_db  = 1'b1;
                ctrl.e_sum       = 1'b1;
                ctrl.subtracting = 1'b1;
                ctrl.carry_in    = 1'b1;   // always binary, no borrow in
            end
            OP_AND: begin
                ctrl.ldb_db = 1'b1;
                ctrl.e_and  = 1'b1;
            end
            OP_ORA: begin
                ctrl.ldb_db = 1'b1;
                ctrl.e_or   = 1'b1;
            end
            OP_EOR: begin
                ctrl.ldb_db = 1'b1;
                ctrl.e_eor  = 1'b1;
            end
            OP_LSR: ctrl.e_shiftr = 1'b1;  // zero into bit 7
            OP_ROR: begin
                ctrl.e_shiftr = 1'b1;
                ctrl.carry_in = status[FLAG_C];
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

/* alu_unit_checker.sv */
`timescale 1ns/100ps
`default_nettype none

module alu_unit_checker (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            cyc,
    input  logic                            stb,
    input  logic                            we,
    input  logic [alu_unit_pkg::ADDR_W-1:0] adr,
    input  logic [alu_unit_pkg::DATA_W-1:0] dat_w,
    input  logic [alu_unit_pkg::DATA_W-1:0] dat_r,
    input  logic                            ack,
    input  logic                            exp_valid,
    input  logic [alu_unit_pkg::DATA_W-1:0] exp_acc,
    input  logic [alu_unit_pkg::DATA_W-1:0] exp_st,
    output int                              error_count,
    output int                              test_count
);
    import alu_unit_pkg::*;

    logic [7:0] m_acc;
    logic [7:0] m_opnd;
    logic [7:0] m_st;
    logic       ack_q;         // ack at the previous edge
    int         test_errs;

    initial begin
        error_count = 0;
        test_count  = 0;
        test_errs   = 0;
    end

    function automatic int from_bcd(input logic [7:0] v);
        return v[7:4] * 10 + v[3:0];
    endfunction

    function automatic logic [7:0] to_bcd(input int v);
        return 8'((v / 10) * 16 + v % 10);
    endfunction

    // reserved status bits drop to 0
    function automatic logic [7:0] keep_flags(input logic [7:0] v);
        logic [7:0] r;
        r         = 8'h00;
        r[FLAG_C] = v[FLAG_C];
        r[FLAG_Z] = v[FLAG_Z];
        r[FLAG_D] = v[FLAG_D];
        r[FLAG_V] = v[FLAG_V];
        r[FLAG_N] = v[FLAG_N];
        return r;
    endfunction

    task automatic compare_value(input string name, input logic [7:0] got,
                                 input logic [7:0] want);
        if (got !== want) begin
            $display("CHECK FAILED %s: got 0x%02h, expected 0x%02h", name, got, want);
            error_count++;
            test_errs++;
        end
    endtask

    // reference model of one opcode on the model registers
    task automatic apply_opcode(input logic [2:0] code);
        logic [8:0] sum;
        logic [7:0] res;
        logic       c;
        logic       v;
        int         dsum;
        c   = m_st[FLAG_C];
        v   = m_st[FLAG_V];
        res = m_acc;
        case (code)
            OP_ADC: begin
                if (m_st[FLAG_D]) begin
                    dsum = from_bcd(m_acc) + from_bcd(m_opnd) + int'(c);
                    res  = to_bcd(dsum % 100);
                    c    = (dsum >= 100);
                    v    = 1'b0;
                end else begin
                    sum = {1'b0, m_acc} + {1'b0, m_opnd} + {8'h00, c};
                    res = sum[7:0];
                    c   = sum[8];
                    v   = (m_acc[7] == m_opnd[7]) && (res[7] != m_acc[7]);
                end
            end
            OP_SBC: begin
                if (m_st[FLAG_D]) begin
                    dsum = from_bcd(m_acc) - from_bcd(m_opnd) - 1 + int'(c);
                    res  = to_bcd((dsum + 100) % 100);
                    c    = (dsum >= 0);     // no borrow
                    v    = 1'b0;
                end else begin
                    sum = {1'b0, m_acc} + {1'b0, ~m_opnd} + {8'h00, c};
                    res = sum[7:0];
                    c   = sum[8];
                    v   = (m_acc[7] != m_opnd[7]) && (res[7] != m_acc[7]);
                end
            end
            OP_AND: res = m_acc & m_opnd;
            OP_ORA: res = m_acc | m_opnd;
            OP_EOR: res = m_acc ^ m_opnd;
            OP_LSR: begin
                res = {1'b0, m_acc[7:1]};
                c   = m_acc[0];
            end
            OP_ROR: begin
                res = {c, m_acc[7:1]};       // old carry into bit 7
                c   = m_acc[0];
            end
            default: begin                   // cmp
                res = m_acc - m_opnd;
                c   = (m_acc >= m_opnd);
            end
        endcase
        m_st = {res[7], v, 2'b00, m_st[FLAG_D], 1'b0, (res == 8'h00), c};
        if (code != OP_CMP) begin
            m_acc = res;
        end
    endtask

    task automatic close_test();
        test_count++;
        if (test_errs == 0) begin
            $display("test %0d passed", test_count);
        end else begin
            $display("test %0d failed with %0d errors", test_count, test_errs);
        end
        test_errs = 0;
    endtask

    always @(posedge clk) begin
        logic [7:0] want;
        string      name;
        if (!rst_n) begin
            m_acc  = '0;
            m_opnd = '0;
            m_st   = '0;
            ack_q  = 1'b0;
        end else begin
            if (ack && ack_q) begin
                $display("ack stayed high for more than one cycle");
                error_count++;
                test_errs++;
            end
            if (ack && !(cyc && stb)) begin
                $display("ack raised with no bus cycle in progress");
                error_count++;
                test_errs++;
            end
            ack_q = ack;
            if (cyc && stb && ack) begin
                if (we) begin
                    case (adr)
                        ADDR_ACC:     m_acc = dat_w;
                        ADDR_OPERAND: m_opnd = dat_w;
                        ADDR_STATUS:  m_st = keep_flags(dat_w);
                        ADDR_OPCODE:  apply_opcode(dat_w[2:0]);
                        default: ;
                    endcase
                end else begin
                    want = 8'h00;                // opcode and unused slots
                    name = "dat_r (opcode)";
                    case (adr)
                        ADDR_ACC: begin
                            want = m_acc;
                            name = "dat_r (acc)";
                        end
                        ADDR_OPERAND: begin
                            want = m_opnd;
                            name = "dat_r (operand)";
                        end
                        ADDR_STATUS: begin
                            want = m_st;
                            name = "dat_r (status)";
                        end
                        default: ;
                    endcase
                    compare_value(name, dat_r, want);
                    if (exp_valid && adr == ADDR_ACC) begin
                        compare_value("dat_r (acc, table)", dat_r, exp_acc);
                    end
                    if (exp_valid && adr == ADDR_STATUS) begin
                        compare_value("dat_r (status, table)", dat_r, exp_st);
                    end
                    if (adr == ADDR_STATUS) begin
                        close_test();            // status read ends each test
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

/* alu_unit_pkg.sv */
`default_nettype none

package alu_unit_pkg;

    localparam int DATA_W = 8;
    localparam int ADDR_W = 3;

    // word addresses on the bus
    localparam logic [ADDR_W-1:0] ADDR_ACC     = 3'd0;
    localparam logic [ADDR_W-1:0] ADDR_OPERAND = 3'd1;
    localparam logic [ADDR_W-1:0] ADDR_STATUS  = 3'd2;
    localparam logic [ADDR_W-1:0] ADDR_OPCODE  = 3'd3; // write only

    // 6502 status layout
    localparam int FLAG_C = 0;
    localparam int FLAG_Z = 1;
    localparam int FLAG_D = 3;
    localparam int FLAG_V = 6;
    localparam int FLAG_N = 7;

    // bits that exist in the status byte
    localparam logic [DATA_W-1:0] STATUS_MASK = 8'b1100_1011;

    typedef enum logic [2:0] {
        OP_ADC = 3'd0,
        OP_SBC = 3'd1,
        OP_AND = 3'd2,
        OP_ORA = 3'd3,
        OP_EOR = 3'd4,
        OP_LSR = 3'd5,
        OP_ROR = 3'd6,
        OP_CMP = 3'd7
    } alu_op_e;

    typedef enum logic [1:0] {
        ST_IDLE = 2'd0,
        ST_EXEC = 2'd1,
        ST_ACK  = 2'd2
    } seq_state_e;

endpackage

`default_nettype wire

/* alu_unit_top.sv */
`timescale 1ns/100ps
`default_nettype none

module alu_unit_top (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            cyc,
    input  logic                            stb,
    input  logic                            we,
    input  logic [alu_unit_pkg::ADDR_W-1:0] adr,
    input  logic [alu_unit_pkg::DATA_W-1:0] dat_w,
    output logic [alu_unit_pkg::DATA_W-1:0] dat_r,
    output logic                            ack
);
    import alu_unit_pkg::*;

    logic [DATA_W-1:0] acc;
    logic [DATA_W-1:0] operand;
    logic [DATA_W-1:0] status;
    logic              acc_we_host;
    logic              operand_we_host;
    logic              status_we_host;
    logic              acc_we_alu;

    alu_ctrl_if ctrl ();

    alu_sequencer u_seq (
        .clk             (clk),
        .rst_n           (rst_n),
        .cyc             (cyc),
        .stb             (stb),
        .we              (we),
        .adr             (adr),
        .dat_w           (dat_w),
        .dat_r           (dat_r),
        .ack             (ack),
        .acc             (acc),
        .operand         (operand),
        .status          (status),
        .acc_we_host     (acc_we_host),
        .operand_we_host (operand_we_host),
        .status_we_host  (status_we_host),
        .acc_we_alu      (acc_we_alu),
        .ctrl            (ctrl.seq)
    );

    operand_regs u_regs (
        .clk             (clk),
        .rst_n           (rst_n),
        .dat_w           (dat_w),
        .acc_we_host     (acc_we_host),
        .operand_we_host (operand_we_host),
        .acc_we_alu      (acc_we_alu),
        .alu_out         (ctrl.alu_out),
        .acc             (acc),
        .operand         (operand)
    );

    alu u_alu (
        .DB_input (operand),
        .SB_input (acc),
        .ctrl     (ctrl.alu)
    );

    status_flags u_flags (
        .clk            (clk),
        .rst_n          (rst_n),
        .dat_w          (dat_w),
        .status_we_host (status_we_host),
        .ctrl           (ctrl.flags),
        .status         (status)
    );

endmodule

`default_nettype wire

/* operand_regs.sv */
`timescale 1ns/100ps
`default_nettype none

module operand_regs (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic [alu_unit_pkg::DATA_W-1:0] dat_w,
    input  logic                            acc_we_host,
    input  logic                            operand_we_host,
    input  logic                            acc_we_alu,
    input  logic [alu_unit_pkg::DATA_W-1:0] alu_out,
    output logic [alu_unit_pkg::DATA_W-1:0] acc,
    output logic [alu_unit_pkg::DATA_W-1:0] operand
);
    import alu_unit_pkg::*;

    logic [DATA_W-1:0] acc_q;
    logic [DATA_W-1:0] operand_q;

    // accumulator, alu write-back before host
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            acc_q <= '0;
        end else if (acc_we_alu) begin
            acc_q <= alu_out;
        end else if (acc_we_host) begin
            acc_q <= dat_w;
        end
    end

    // operand, host only
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            operand_q <= '0;
        end else if (operand_we_host) begin
            operand_q <= dat_w;
        end
    end

    assign acc     = acc_q;        // feeds sb
    assign operand = operand_q;    // feeds db

endmodule

`default_nettype wire

/* status_flags.sv */
`timescale 1ns/100ps
`default_nettype none

module status_flags (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic [alu_unit_pkg::DATA_W-1:0] dat_w,
    input  logic                            status_we_host,
    alu_ctrl_if.flags                       ctrl,
    output logic [alu_unit_pkg::DATA_W-1:0] status
);
    import alu_unit_pkg::*;

    logic upd_c;
    logic upd_v;

    // which opcodes touch c and v
    always_comb begin
        upd_c = 1'b0;
        upd_v = 1'b0;
        case (ctrl.op)
            OP_ADC, OP_SBC: begin
                upd_c = 1'b1;
                upd_v = 1'b1;
            end
            OP_CMP, OP_LSR, OP_ROR: upd_c = 1'b1;
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            status <= '0;
        end else if (ctrl.flag_we) begin
            status[FLAG_N] <= ctrl.alu_out[DATA_W-1];
            status[FLAG_Z] <= (ctrl.alu_out == '0);
            if (upd_c) begin
                status[FLAG_C] <= ctrl.carry_out;
            end
            if (upd_v) begin
                status[FLAG_V] <= ctrl.overflow;
            end
        end else if (status_we_host) begin
            status <= dat_w & STATUS_MASK;   // reserved bits held at 0
        end
    end

endmodule

`default_nettype wire

/* tb_alu_unit.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_alu_unit;
    import alu_unit_pkg::*;

    localparam int     CLK_NS       = 20;
    localparam int     NUM_DIRECTED = 20;
    localparam int     NUM_ROWS     = 28;
    localparam int     ACCESSES     = 8;    // per test
    localparam longint TIMEOUT_NS   = (NUM_ROWS + 1) * ACCESSES * 4 * CLK_NS + 10 * CLK_NS;

    logic              clk;
    logic              rst_n;
    logic              cyc;
    logic              stb;
    logic              we;
    logic [ADDR_W-1:0] adr;
    logic [DATA_W-1:0] dat_w;
    logic [DATA_W-1:0] dat_r;
    logic              ack;
    logic              exp_valid;
    logic [7:0]        exp_acc;
    logic [7:0]        exp_st;
    int                error_count;
    int                test_count;

    // acc, operand, status, opcode, expected acc, expected status
    logic [42:0] rows [NUM_ROWS];

    alu_unit_top dut_i (
        .clk   (clk),
        .rst_n (rst_n),
        .cyc   (cyc),
        .stb   (stb),
        .we    (we),
        .adr   (adr),
        .dat_w (dat_w),
        .dat_r (dat_r),
        .ack   (ack)
    );

    alu_unit_checker chk_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .cyc         (cyc),
        .stb         (stb),
        .we          (we),
        .adr         (adr),
        .dat_w       (dat_w),
        .dat_r       (dat_r),
        .ack         (ack),
        .exp_valid   (exp_valid),
        .exp_acc     (exp_acc),
        .exp_st      (exp_st),
        .error_count (error_count),
        .test_count  (test_count)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_NS / 2) clk = ~clk;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("timeout: bus accesses still pending after %0d ns", TIMEOUT_NS);
        $display("Simulation finished: FAIL");
        $finish;
    end

    // one classic cycle, entered and left 2 ns after a rising edge
    task automatic bus_cycle(input logic write, input logic [ADDR_W-1:0] addr,
                             input logic [DATA_W-1:0] data);
        cyc   = 1'b1;
        stb   = 1'b1;
        we    = write;
        adr   = addr;
        dat_w = data;
        do begin
            @(posedge clk);
            #2;
        end while (!ack);
        @(posedge clk);                      // ack drops here
        #2;
        cyc = 1'b0;
        stb = 1'b0;
        we  = 1'b0;
    endtask

    task automatic check_registers();
        bus_cycle(1'b0, ADDR_ACC, 8'h00);
        bus_cycle(1'b0, ADDR_OPERAND, 8'h00);
        bus_cycle(1'b0, ADDR_OPCODE, 8'h00);
        bus_cycle(1'b0, ADDR_STATUS, 8'h00);
    endtask

    initial begin
        logic [7:0] a;
        logic [7:0] m;
        logic [7:0] s;
        logic [7:0] ea;
        logic [7:0] es;
        logic [2:0] code;
        void'($urandom(32'h15d3_4366));
        rst_n     = 1'b0;
        cyc       = 1'b0;
        stb       = 1'b0;
        we        = 1'b0;
        adr       = '0;
        dat_w     = '0;
        exp_valid = 1'b0;
        exp_acc   = 8'h00;
        exp_st    = 8'h00;

        rows[0]  = {8'h7F, 8'h01, 8'h00, OP_ADC, 8'h80, 8'hC0};   // sets v
        rows[1]  = {8'hFF, 8'h01, 8'h00, OP_ADC, 8'h00, 8'h03};
        rows[2]  = {8'h50, 8'h10, 8'h01, OP_ADC, 8'h61, 8'h00};
        rows[3]  = {8'h80, 8'h01, 8'h01, OP_SBC, 8'h7F, 8'h41};
        rows[4]  = {8'h05, 8'h05, 8'h01, OP_SBC, 8'h00, 8'h03};
        rows[5]  = {8'h03, 8'h05, 8'h00, OP_SBC, 8'hFD, 8'h80};
        rows[6]  = {8'h45, 8'h38, 8'h08, OP_ADC, 8'h83, 8'h88};   // bcd
        rows[7]  = {8'h99, 8'h01, 8'h09, OP_ADC, 8'h01, 8'h09};
        rows[8]  = {8'h50, 8'h50, 8'h08, OP_ADC, 8'h00, 8'h0B};
        rows[9]  = {8'h42, 8'h13, 8'h09, OP_SBC, 8'h29, 8'h09};
        rows[10] = {8'h12, 8'h34, 8'h09, OP_SBC, 8'h78, 8'h08};   // bcd borrow
        rows[11] = {8'hF0, 8'h3C, 8'h41, OP_AND, 8'h30, 8'h41};
        rows[12] = {8'h00, 8'h00, 8'h00, OP_ORA, 8'h00, 8'h02};
        rows[13] = {8'hAA, 8'h55, 8'hFF, OP_EOR, 8'hFF, 8'hC9};   // reserved bits
        rows[14] = {8'h81, 8'h00, 8'h00, OP_LSR, 8'h40, 8'h01};
        rows[15] = {8'h81, 8'h00, 8'h01, OP_ROR, 8'hC0, 8'h81};
        rows[16] = {8'h02, 8'h00, 8'h00, OP_ROR, 8'h01, 8'h00};
        rows[17] = {8'h40, 8'h40, 8'h00, OP_CMP, 8'h40, 8'h03};
        rows[18] = {8'h10, 8'h20, 8'h08, OP_CMP, 8'h10, 8'h88};
        rows[19] = {8'h90, 8'h10, 8'h40, OP_CMP, 8'h90, 8'hC1};
        for (int i = NUM_DIRECTED; i < NUM_ROWS; i++) begin
            rows[i] = {8'($urandom), 8'($urandom), 8'($urandom & 32'h41),
                       3'($urandom), 16'h0000};   // binary, checked by model only
        end

        repeat (10) @(posedge clk);
        #2;
        rst_n = 1'b1;

        exp_valid = 1'b1;                    // everything reads 0 after reset
        check_registers();

        for (int i = 0; i < NUM_ROWS; i++) begin
            {a, m, s, code, ea, es} = rows[i];
            exp_valid = (i < NUM_DIRECTED);
            exp_acc   = ea;
            exp_st    = es;
            bus_cycle(1'b1, ADDR_ACC, a);
            bus_cycle(1'b1, ADDR_OPERAND, m);
            bus_cycle(1'b1, ADDR_STATUS, s);
            bus_cycle(1'b1, ADDR_OPCODE, {5'b00000, code});
            check_registers();
        end

        $display("%0d tests run, %0d checks failed", test_count, error_count);
        if (test_count != NUM_ROWS + 1) begin
            $display("only %0d of %0d tests completed", test_count, NUM_ROWS + 1);
        end
        if (error_count == 0 && test_count == NUM_ROWS + 1) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verilog.f */
alu_unit_pkg.sv
alu_ctrl_if.sv
alu.sv
alu_sequencer.sv
operand_regs.sv
status_flags.sv
alu_unit_top.sv
alu_unit_checker.sv
tb_alu_unit.sv
